// File: design/icache_pkg.sv
`default_nettype none

package icache_pkg;

   // fetch address, doubleword granular
   // bits 2..0 never travel, the fetch unit asks for whole doublewords
   typedef logic [31:3] addr_t;

   // one instruction doubleword
   typedef logic [63:0] data_t;

   // byte offset bits of a 32-byte line
   localparam int line_byte_bits = 5;

   // word-in-line select, four doublewords per line
   localparam int line_off_bits = 2;

   // one bus beat per doubleword
   localparam int fill_beats = 4;

   // linefill sequencing
   // lf_req holds the line request until the bus acknowledges
   // lf_fill covers the beats up to and including the last one
   typedef enum logic [1:0] {
      lf_idle,
      lf_req,
      lf_fill
   } lf_state_t;

   // tag width left above index and line offset
   // index_bits 10 gives 17 tag bits, i.e. addr[31:15]
   function automatic int tag_bits_f(input int index_bits);
      int tag_bits;
      tag_bits = 32 - line_byte_bits - index_bits;
      return tag_bits;
   endfunction

endpackage

`default_nettype wire

// File: design/icache_array_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_array_if #(
   parameter int index_bits = 10
);

   localparam int tag_bits = icache_pkg::tag_bits_f(index_bits);

   // lookup side, ic1 command
   logic                                 lu_en;
   logic [index_bits-1:0]                lu_index;
   logic [icache_pkg::line_off_bits-1:0] lu_word;
   // ic2 address tag, also the tag written on fill
   logic [tag_bits-1:0]                  cmp_tag;

   // fill side, one beat per strobe
   logic                                 fill_we;
   logic                                 fill_way;
   logic [index_bits-1:0]                fill_index;
   logic [icache_pkg::line_off_bits-1:0] fill_word;
   logic                                 tag_we;

   // ic2 results from the tag array
   logic                                 hit;
   logic                                 hit_way;
   logic [1:0]                           way_valid;

   modport ctrl (
      output lu_en, lu_index, lu_word, cmp_tag,
      output fill_we, fill_way, fill_index, fill_word, tag_we,
      input  hit, way_valid
   );

   modport tag (
      input  lu_en, lu_index, cmp_tag, tag_we, fill_way, fill_index,
      output hit, hit_way, way_valid
   );

   modport data (
      input  lu_en, lu_index, lu_word,
      input  fill_we, fill_way, fill_index, fill_word,
      input  hit, hit_way
   );

endinterface

`default_nettype wire

// File: design/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl #(
   parameter int index_bits = 10
) (
   input  wire                                  clk,
   input  wire                                  arst_n,
   input  wire                                  fetch_req,
   input  wire icache_pkg::addr_t               fetch_addr,
   input  wire                                  fetch_cancel,
   input  wire                                  biu_ack,
   input  wire                                  biu_data_valid,
   input  wire                                  biu_data_last,
   output logic                                 fetch_ack,
   output logic                                 fetch_valid,
   output logic                                 biu_req,
   output icache_pkg::addr_t                    biu_addr,
   output logic [icache_pkg::line_off_bits-1:0] lfb_word,
   icache_array_if.ctrl                         arr
);

   localparam int tag_bits = icache_pkg::tag_bits_f(index_bits);
   localparam int off_bits = icache_pkg::line_byte_bits;

   logic                                 lu_ic1;
   logic                                 lu_ic2_q;
   logic                                 lu_inprog_q;
   icache_pkg::addr_t                    addr_ic2_q;
   logic                                 miss_ic2;
   logic                                 fill_beat;
   logic                                 fill_last;
   logic                                 data_valid;
   logic                                 cancel_q;
   icache_pkg::lf_state_t                lf_state_q;
   icache_pkg::lf_state_t                lf_state_d;
   logic [icache_pkg::line_off_bits-1:0] beat_q;
   logic                                 way_q;
   logic [index_bits-1:0]                arr_index;
   logic [icache_pkg::line_off_bits-1:0] arr_word;

   // one lookup at a time, a linefill counts as part of its lookup
   assign fetch_ack = fetch_req & ~lu_inprog_q;
   assign lu_ic1    = fetch_req & fetch_ack;

   assign miss_ic2   = lu_ic2_q & ~arr.hit;
   assign fill_beat  = (lf_state_q == icache_pkg::lf_fill) & biu_data_valid;
   assign fill_last  = fill_beat & biu_data_last;
   // internal delivery, hit or last beat of the fill
   assign data_valid = arr.hit | fill_last;
   // a live cancel or an armed one swallows this delivery
   assign fetch_valid = data_valid & ~(fetch_cancel | cancel_q);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lu_ic2_q    <= 1'b0;
         lu_inprog_q <= 1'b0;
         cancel_q    <= 1'b0;
      end else begin
         lu_ic2_q    <= lu_ic1;
         lu_inprog_q <= (lu_inprog_q & ~data_valid) | lu_ic1;
         // arm on cancel, clear on delivery
         if (fetch_cancel | data_valid) begin
            cancel_q <= fetch_cancel & ~data_valid;
         end
      end
   end

   // ic2 address, held through the whole fill
   always_ff @(posedge clk) begin
      if (lu_ic1) begin
         addr_ic2_q <= fetch_addr;
      end
   end

   always_comb begin
      lf_state_d = lf_state_q;
      case (lf_state_q)
         icache_pkg::lf_idle: begin
            // ack may come back in the miss cycle itself
            if (miss_ic2) begin
               lf_state_d = biu_ack ? icache_pkg::lf_fill : icache_pkg::lf_req;
            end
         end
         icache_pkg::lf_req: begin
            if (biu_ack) begin
               lf_state_d = icache_pkg::lf_fill;
            end
         end
         icache_pkg::lf_fill: begin
            if (fill_last) begin
               lf_state_d = icache_pkg::lf_idle;
            end
         end
         default: lf_state_d = icache_pkg::lf_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lf_state_q <= icache_pkg::lf_idle;
         beat_q     <= '0;
         way_q      <= 1'b0;
      end else begin
         lf_state_q <= lf_state_d;
         // beats land at words 0..3 in order
         if (miss_ic2) begin
            beat_q <= '0;
         end else if (fill_beat) begin
            beat_q <= beat_q + 1'b1;
         end
         // way0 by default, way1 only if way0 taken and way1 free
         if (miss_ic2) begin
            way_q <= arr.way_valid[0] & ~arr.way_valid[1];
         end
      end
   end

   // request straight from the miss, then held by lf_req
   assign biu_req  = miss_ic2 | (lf_state_q == icache_pkg::lf_req);
   assign biu_addr = {addr_ic2_q[31:off_bits], {icache_pkg::line_off_bits{1'b0}}};
   assign lfb_word = addr_ic2_q[off_bits-1 -: icache_pkg::line_off_bits];

   // ic1 address while looking up, else ic2 line plus beat count
   assign arr_index = lu_ic1 ? fetch_addr[off_bits +: index_bits]
                             : addr_ic2_q[off_bits +: index_bits];
   assign arr_word  = lu_ic1 ? fetch_addr[off_bits-1 -: icache_pkg::line_off_bits] : beat_q;

   assign arr.lu_en      = lu_ic1;
   assign arr.lu_index   = arr_index;
   assign arr.lu_word    = arr_word;
   assign arr.cmp_tag    = addr_ic2_q[31 -: tag_bits];
   assign arr.fill_we    = fill_beat;
   assign arr.fill_way   = way_q;
   assign arr.fill_index = arr_index;
   assign arr.fill_word  = arr_word;
   assign arr.tag_we     = fill_last;

   // a miss is only possible from idle
   assert property (@(posedge clk) disable iff (!arst_n)
      lf_state_q == icache_pkg::lf_fill |-> !biu_req);

   // beats only follow an outstanding line request
   assert property (@(posedge clk) disable iff (!arst_n)
      biu_data_valid |-> lf_state_q != icache_pkg::lf_idle);

endmodule

`default_nettype wire

// File: design/icache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array #(
   parameter int index_bits = 10
) (
   input  wire         clk,
   input  wire         arst_n,
   icache_array_if.tag arr
);

   localparam int tag_bits = icache_pkg::tag_bits_f(index_bits);
   localparam int sets     = 1 << index_bits;

   typedef struct packed {
      logic                valid;
      logic [tag_bits-1:0] tag;
   } tag_entry_t;

   logic [1:0][sets-1:0] valid_q;
   logic [tag_bits-1:0]  tag_mem [2][sets];
   tag_entry_t [1:0]     rd_q;
   logic                 lu_q;
   logic [1:0]           match;

   // valid bits cleared on reset, tags left as they are
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         lu_q    <= 1'b0;
      end else begin
         lu_q <= arr.lu_en;
         if (arr.tag_we) begin
            valid_q[arr.fill_way][arr.fill_index] <= 1'b1;
         end
      end
   end

   // both ways read at ic1, entry written on the last beat
   always_ff @(posedge clk) begin
      if (arr.lu_en) begin
         for (int w = 0; w < 2; w++) begin
            rd_q[w] <= '{valid: valid_q[w][arr.lu_index], tag: tag_mem[w][arr.lu_index]};
         end
      end
      if (arr.tag_we) begin
         tag_mem[arr.fill_way][arr.fill_index] <= arr.cmp_tag;
      end
   end

   // ic2 compare
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         match[w] = rd_q[w].valid & (rd_q[w].tag == arr.cmp_tag);
      end
   end

   assign arr.hit       = lu_q & (|match);
   assign arr.hit_way   = match[1];
   assign arr.way_valid = {rd_q[1].valid, rd_q[0].valid};

   // a line is only ever allocated into one way of its set
   assert property (@(posedge clk) disable iff (!arst_n) lu_q |-> !(&match));

endmodule

`default_nettype wire

// File: design/icache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_array #(
   parameter int index_bits = 10
) (
   input  wire                clk,
   input  wire icache_pkg::data_t fill_data,
   output icache_pkg::data_t  rd_data,
   icache_array_if.data       arr
);

   localparam int sets      = 1 << index_bits;
   localparam int words     = sets * icache_pkg::fill_beats;
   localparam int addr_bits = index_bits + icache_pkg::line_off_bits;

   icache_pkg::data_t    mem [2][words];
   icache_pkg::data_t    rd_q [2];
   logic [addr_bits-1:0] rd_addr;
   logic [addr_bits-1:0] wr_addr;

   // word address is set index over word in line
   assign rd_addr = {arr.lu_index, arr.lu_word};
   assign wr_addr = {arr.fill_index, arr.fill_word};

   // all ways read at ic1, one beat written per fill strobe
   always_ff @(posedge clk) begin
      if (arr.lu_en) begin
         for (int w = 0; w < 2; w++) begin
            rd_q[w] <= mem[w][rd_addr];
         end
      end
      if (arr.fill_we) begin
         mem[arr.fill_way][wr_addr] <= fill_data;
      end
   end

   // ic2 way select, zero unless a way hit
   assign rd_data = arr.hit ? rd_q[arr.hit_way] : '0;

endmodule

`default_nettype wire

// File: design/icache_lfb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_lfb (
   input  wire                                  clk,
   input  wire                                  arst_n,
   input  wire                                  biu_data_valid,
   input  wire                                  biu_data_last,
   input  wire icache_pkg::data_t               biu_data,
   input  wire [icache_pkg::line_off_bits-1:0]  word_sel,
   output logic                                 lfb_valid,
   output icache_pkg::data_t                    lfb_data
);

   localparam int beats = icache_pkg::fill_beats;

   logic [beats-1:0]  ptr_q;
   icache_pkg::data_t beat_q [beats];

   // one-hot beat pointer, back to word 0 after the last beat
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_q <= 1;
      end else if (biu_data_valid) begin
         if (biu_data_last) begin
            ptr_q <= 1;
         end else begin
            ptr_q <= {ptr_q[beats-2:0], ptr_q[beats-1]};
         end
      end
   end

   // capture each beat in its own slot
   always_ff @(posedge clk) begin
      for (int i = 0; i < beats; i++) begin
         if (biu_data_valid && ptr_q[i]) begin
            beat_q[i] <= biu_data;
         end
      end
   end

   assign lfb_valid = biu_data_valid & biu_data_last;
   // last word is still on the bus, not yet in its slot
   assign lfb_data  = (word_sel == beats - 1) ? biu_data : beat_q[word_sel];

   // a line is always four beats
   assert property (@(posedge clk) disable iff (!arst_n)
      biu_data_valid && biu_data_last |-> ptr_q[beats-1]);

endmodule

`default_nettype wire

// File: design/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
   parameter int index_bits = 10
) (
   input  wire                    clk,
   input  wire                    arst_n,
   // fetch side
   input  wire                    fetch_req,
   input  wire icache_pkg::addr_t fetch_addr,
   output logic                   fetch_ack,
   input  wire                    fetch_cancel,
   output logic                   fetch_valid,
   output icache_pkg::data_t      fetch_data,
   // bus side
   output logic                   biu_req,
   output icache_pkg::addr_t      biu_addr,
   input  wire                    biu_ack,
   input  wire                    biu_data_valid,
   input  wire                    biu_data_last,
   input  wire icache_pkg::data_t biu_data
);

   logic [icache_pkg::line_off_bits-1:0] lfb_word;
   logic                                 lfb_valid;
   icache_pkg::data_t                    lfb_data;
   icache_pkg::data_t                    rd_data;

   icache_array_if #(.index_bits(index_bits)) arr_if ();

   icache_ctrl #(.index_bits(index_bits)) ctrl_i (
      .clk, .arst_n, .fetch_req, .fetch_addr, .fetch_cancel,
      .biu_ack, .biu_data_valid, .biu_data_last,
      .fetch_ack, .fetch_valid, .biu_req, .biu_addr,
      .lfb_word, .arr (arr_if.ctrl)
   );

   icache_tag_array #(.index_bits(index_bits)) tag_i (
      .clk, .arst_n, .arr (arr_if.tag)
   );

   // fill data comes straight off the bus
   icache_data_array #(.index_bits(index_bits)) data_i (
      .clk, .fill_data (biu_data), .rd_data, .arr (arr_if.data)
   );

   icache_lfb lfb_i (
      .clk, .arst_n, .biu_data_valid, .biu_data_last, .biu_data,
      .word_sel (lfb_word), .lfb_valid, .lfb_data
   );

   // array word on a hit, buffer word on the last fill beat
   assign fetch_data = lfb_valid ? lfb_data : rd_data;

endmodule

`default_nettype wire

// File: bench/icache_biu_model.sv
`timescale 1ns/1ns
`default_nettype none

module icache_biu_model (
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire                    biu_req,
   input  wire icache_pkg::addr_t biu_addr,
   output logic                   biu_ack,
   output logic                   biu_data_valid,
   output logic                   biu_data_last,
   output icache_pkg::data_t      biu_data
);

   // upper half is line and word, lower half its inverse
   function automatic icache_pkg::data_t beat_data(input icache_pkg::addr_t line, input int beat);
      logic [31:0] hi;
      hi = {3'b000, line[31:5], beat[1:0]};
      return {hi, ~hi};
   endfunction

   initial begin
      icache_pkg::addr_t line;
      int                delay;
      biu_ack        = 1'b0;
      biu_data_valid = 1'b0;
      biu_data_last  = 1'b0;
      biu_data       = '0;
      forever begin
         // request sampled mid-cycle
         @(negedge clk);
         if (arst_n && biu_req) begin
            line  = biu_addr;
            // back-pressure, 1 to 4 cycles before the ack
            delay = 1 + $urandom % 4;
            repeat (delay) @(posedge clk);
            #5 biu_ack = 1'b1;
            @(posedge clk);
            #5 biu_ack = 1'b0;
            // beats start the cycle after the ack
            for (int b = 0; b < icache_pkg::fill_beats; b++) begin
               biu_data_valid = 1'b1;
               biu_data_last  = (b == icache_pkg::fill_beats - 1);
               biu_data       = beat_data(line, b);
               @(posedge clk);
               #5;
            end
            biu_data_valid = 1'b0;
            biu_data_last  = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

   localparam int index_bits = 10;
   localparam int sets       = 1 << index_bits;
   localparam int tag_lo     = 5 + index_bits;
   localparam int clk_period = 40;
   localparam int num_tests  = 6;
   // one set shared by the two-way tests, another for cancel
   localparam int line_idx   = 5;
   localparam int cancel_idx = 6;
   localparam int tag_a      = 'h155;
   localparam int tag_b      = 'h2aa;
   localparam int tag_c      = 'h3c3;
   localparam int tag_d      = 'h0f0;

   logic              clk = 1'b0;
   logic              arst_n;
   logic              fetch_req;
   icache_pkg::addr_t fetch_addr;
   logic              fetch_ack;
   logic              fetch_cancel;
   logic              fetch_valid;
   icache_pkg::data_t fetch_data;
   logic              biu_req;
   icache_pkg::addr_t biu_addr;
   logic              biu_ack;
   logic              biu_data_valid;
   logic              biu_data_last;
   icache_pkg::data_t biu_data;

   int checks = 0;
   int errors = 0;

   // reference tag state per way and set
   bit          model_valid [2][sets];
   logic [31:0] model_tag   [2][sets];

   always #(clk_period / 2) clk = ~clk;

   icache_top #(.index_bits(index_bits)) dut_i (.*);

   icache_biu_model biu_i (
      .clk, .arst_n, .biu_req, .biu_addr,
      .biu_ack, .biu_data_valid, .biu_data_last, .biu_data
   );

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic icache_pkg::addr_t make_addr(input int tag, input int idx, input int word);
      icache_pkg::addr_t a;
      a              = '0;
      a[31:tag_lo]   = tag[31-tag_lo:0];
      a[tag_lo-1:5]  = idx[index_bits-1:0];
      a[4:3]         = word[1:0];
      return a;
   endfunction

   // doubleword address and its inverse
   function automatic icache_pkg::data_t expected_word(input icache_pkg::addr_t addr);
      logic [31:0] hi;
      hi = {3'b000, addr};
      return {hi, ~hi};
   endfunction

   // one fetch, checked against the reference tag state
   task automatic lookup(input icache_pkg::addr_t addr, input bit cancel, output bit missed);
      int idx;
      bit hit;
      int way;
      int waited;
      idx = int'(addr[tag_lo-1:5]);
      hit = 1'b0;
      for (int w = 0; w < 2; w++) begin
         if (model_valid[w][idx] && model_tag[w][idx] == 32'(addr[31:tag_lo])) begin
            hit = 1'b1;
         end
      end
      @(posedge clk);
      #5;
      fetch_req  = 1'b1;
      fetch_addr = addr;
      @(negedge clk);
      // previous lookup has finished, so no wait for ack
      check_eq("fetch_ack", fetch_ack, 1);
      @(posedge clk);
      #5;
      fetch_req = 1'b0;
      // ic2 cycle
      @(negedge clk);
      missed = biu_req;
      check_eq("biu_req", biu_req, !hit);
      if (hit) begin
         check_eq("fetch_valid", fetch_valid, 1);
         check_eq("fetch_data", fetch_data, expected_word(addr));
         @(negedge clk);
         check_eq("fetch_valid", fetch_valid, 0);
      end else begin
         check_eq("fetch_valid", fetch_valid, 0);
         check_eq("biu_addr", biu_addr, {addr[31:5], 2'b00});
         // cancel lands before the earliest beat
         if (cancel) begin
            @(posedge clk);
            #5;
            fetch_cancel = 1'b1;
            @(posedge clk);
            #5;
            fetch_cancel = 1'b0;
         end
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!(biu_data_valid && biu_data_last) && waited < 40);
         if (biu_data_valid && biu_data_last) begin
            check_eq("fetch_valid", fetch_valid, !cancel);
            if (!cancel) begin
               check_eq("fetch_data", fetch_data, expected_word(addr));
            end
         end else begin
            errors++;
            $display("linefill for address %h never delivered its last beat", addr);
         end
         // way1 only when way0 valid and way1 free
         way = (model_valid[0][idx] && !model_valid[1][idx]) ? 1 : 0;
         model_valid[way][idx] = 1'b1;
         model_tag[way][idx]   = 32'(addr[31:tag_lo]);
      end
   endtask

   task automatic reset_state();
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #5;
      fetch_req = 1'b1;
      @(negedge clk);
      check_eq("fetch_ack", fetch_ack, 1);
      check_eq("fetch_valid", fetch_valid, 0);
      check_eq("biu_req", biu_req, 0);
      @(posedge clk);
      #5;
      fetch_req = 1'b0;
      @(negedge clk);
      check_eq("fetch_ack", fetch_ack, 0);
      // eight cycles of reset in all
      repeat (5) @(posedge clk);
      #5;
      arst_n = 1'b1;
      @(negedge clk);
      check_eq("fetch_valid", fetch_valid, 0);
      check_eq("biu_req", biu_req, 0);
      check_eq("fetch_ack", fetch_ack, 0);
   endtask

   task automatic cold_miss();
      bit missed;
      lookup(make_addr(tag_a, line_idx, 2), 1'b0, missed);
      check_eq("miss", missed, 1);
   endtask

   task automatic hits_after_fill();
      bit missed;
      for (int w = 0; w < 4; w++) begin
         lookup(make_addr(tag_a, line_idx, w), 1'b0, missed);
         check_eq("miss", missed, 0);
      end
   endtask

   task automatic two_way();
      bit missed;
      // second line goes to way1
      lookup(make_addr(tag_b, line_idx, 1), 1'b0, missed);
      check_eq("miss", missed, 1);
      lookup(make_addr(tag_a, line_idx, 0), 1'b0, missed);
      check_eq("miss", missed, 0);
      lookup(make_addr(tag_b, line_idx, 3), 1'b0, missed);
      check_eq("miss", missed, 0);
      // set full, third line evicts way0
      lookup(make_addr(tag_c, line_idx, 3), 1'b0, missed);
      check_eq("miss", missed, 1);
      lookup(make_addr(tag_a, line_idx, 1), 1'b0, missed);
      check_eq("miss", missed, 1);
      lookup(make_addr(tag_b, line_idx, 2), 1'b0, missed);
      check_eq("miss", missed, 0);
   endtask

   task automatic cancel_miss();
      bit missed;
      lookup(make_addr(tag_d, cancel_idx, 3), 1'b1, missed);
      check_eq("miss", missed, 1);
      // line was still written, so this one hits
      lookup(make_addr(tag_d, cancel_idx, 3), 1'b0, missed);
      check_eq("miss", missed, 0);
   endtask

   task automatic random_lookups();
      icache_pkg::addr_t addr;
      bit                missed;
      // four tags over four sets keeps conflicts frequent
      for (int i = 0; i < 40; i++) begin
         addr = make_addr(1 + $urandom % 4, 8 + $urandom % 4, $urandom % 4);
         lookup(addr, 1'b0, missed);
      end
   endtask

   initial begin
      #(num_tests * 200 * clk_period);
      $display("run stopped after %0d cycles without finishing", num_tests * 200);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      void'($urandom(58022));
      arst_n       = 1'b0;
      fetch_req    = 1'b0;
      fetch_addr   = '0;
      fetch_cancel = 1'b0;
      reset_state();
      cold_miss();
      hits_after_fill();
      two_way();
      cancel_miss();
      random_lookups();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
design/icache_pkg.sv
design/icache_array_if.sv
design/icache_ctrl.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lfb.sv
design/icache_top.sv
bench/icache_biu_model.sv
bench/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_array_if.sv
  - design/icache_ctrl.sv
  - design/icache_tag_array.sv
  - design/icache_data_array.sv
  - design/icache_lfb.sv
  - design/icache_top.sv
  - target: test
    files:
      - bench/icache_biu_model.sv
      - bench/icache_tb.sv
